// File: rtl/spy_pkg.sv
// Shared widths and address maps for the spy examine port
// Read and load maps are word addresses, taken from AXI address bits 6:2

package spy_pkg;

   // Bus side
   localparam int axi_addr_w = 7;
   localparam int axi_data_w = 32;
   localparam int resp_w     = 2;

   localparam logic [resp_w-1:0] resp_okay   = 2'b00;
   localparam logic [resp_w-1:0] resp_slverr = 2'b10;

   // Spy side
   localparam int spy_data_w = 16;
   localparam int eadr_w     = 5;
   localparam int n_read_sel = 24;
   localparam int n_load_sel = 12;

   // Stand-in target widths
   localparam int pc_w   = 14;
   localparam int dbir_w = 3 * spy_data_w;
   localparam int mach_w = 2 * spy_data_w;

   // Read map
   localparam int rd_irl     = 0;
   localparam int rd_irm     = 1;
   localparam int rd_irh     = 2;
   localparam int rd_scratch = 3;
   localparam int rd_opc     = 4;
   localparam int rd_pc      = 5;
   localparam int rd_obl     = 6;
   localparam int rd_obh     = 7;
   localparam int rd_flag1   = 8;
   localparam int rd_flag2   = 9;
   localparam int rd_ml      = 10;
   localparam int rd_mh      = 11;
   localparam int rd_al      = 12;
   localparam int rd_ah      = 13;
   localparam int rd_stl     = 14;
   localparam int rd_sth     = 15;
   localparam int rd_mdl     = 16;
   localparam int rd_mdh     = 17;
   localparam int rd_vmal    = 18;
   localparam int rd_vmah    = 19;
   localparam int rd_obl_n   = 20;
   localparam int rd_obh_n   = 21;
   localparam int rd_disk    = 22;
   localparam int rd_bd      = 23;

   // Load map
   localparam int ld_dbirl    = 0;
   localparam int ld_dbirm    = 1;
   localparam int ld_dbirh    = 2;
   localparam int ld_clk      = 3;
   localparam int ld_opc      = 4;
   localparam int ld_mode     = 5;
   localparam int ld_scratch1 = 6;
   localparam int ld_scratch2 = 7;
   localparam int ld_mdl      = 8;
   localparam int ld_mdh      = 9;
   localparam int ld_vmal     = 10;
   localparam int ld_vmah     = 11;

endpackage

// File: rtl/spy_axil_slave.sv
// AXI4-Lite front end, one outstanding transaction per channel
// A write waits until awvalid and wvalid are high together; writes win over reads
// Only wdata[15:0] is used, and it needs wstrb[1:0] both set

`timescale 1ns/10ps

module spy_axil_slave (
   input  logic                              clk,
   input  logic                              rst_n,

   // Write address and data
   input  logic [spy_pkg::axi_addr_w-1:0]    awaddr,
   input  logic                              awvalid,
   output logic                              awready,
   input  logic [spy_pkg::axi_data_w-1:0]    wdata,
   input  logic [spy_pkg::axi_data_w/8-1:0]  wstrb,
   input  logic                              wvalid,
   output logic                              wready,

   // Write response
   output logic [spy_pkg::resp_w-1:0]        bresp,
   output logic                              bvalid,
   input  logic                              bready,

   // Read address and data
   input  logic [spy_pkg::axi_addr_w-1:0]    araddr,
   input  logic                              arvalid,
   output logic                              arready,
   output logic [spy_pkg::axi_data_w-1:0]    rdata,
   output logic [spy_pkg::resp_w-1:0]        rresp,
   output logic                              rvalid,
   input  logic                              rready,

   // Spy side
   output logic [spy_pkg::eadr_w-1:0]        eadr,
   output logic                              dbread,
   output logic                              dbwrite,
   output logic [spy_pkg::spy_data_w-1:0]    spy_wdata,
   input  logic [spy_pkg::spy_data_w-1:0]    rd_word,
   input  logic                              hit
);
   import spy_pkg::*;

   logic wr_go;
   logic rd_go;
   logic full_strobe;

   // Accept conditions
   assign wr_go = awvalid && wvalid && !bvalid;
   // Read waits a cycle when a write is taken
   assign rd_go = arvalid && !rvalid && !wr_go;

   assign full_strobe = &wstrb[1:0];

   assign awready = wr_go;
   assign wready  = wr_go;
   assign arready = rd_go;

   // Word address from bits 6:2 of whichever channel is active
   assign eadr = wr_go ? awaddr[eadr_w+1:2] : araddr[eadr_w+1:2];

   // Partial strobes still complete the handshake, but load nothing
   assign dbwrite   = wr_go && full_strobe;
   assign dbread    = rd_go;
   assign spy_wdata = wdata[spy_data_w-1:0];

   // Response valid flags
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bvalid <= 1'b0;
         rvalid <= 1'b0;
      end else begin
         if (wr_go) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end

         if (rd_go) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
      end
   end

   // Response payload, captured in the pulse cycle
   always_ff @(posedge clk) begin
      if (wr_go) begin
         // An ignored partial write is still OKAY
         bresp <= (dbwrite && !hit) ? resp_slverr : resp_okay;
      end

      if (rd_go) begin
         rresp <= hit ? resp_okay : resp_slverr;
         if (hit) begin
            rdata <= {{(axi_data_w-spy_data_w){1'b0}}, rd_word};
         end else begin
            rdata <= '0;
         end
      end
   end

endmodule

// File: rtl/spy_decode.sv
// Examine address decoder, purely combinational
// One read select per dbread pulse, one load strobe per dbwrite pulse
// hit means the address is mapped for the pulsing direction

`timescale 1ns/10ps

module spy_decode (
   input  logic [spy_pkg::eadr_w-1:0]     eadr,
   input  logic                           dbread,
   input  logic                           dbwrite,
   output logic [spy_pkg::n_read_sel-1:0] read_sel,
   output logic [spy_pkg::n_load_sel-1:0] load_sel,
   output logic                           hit
);
   import spy_pkg::*;

   // Read selects, address 0 to 23
   always_comb begin
      read_sel = '0;
      for (int i = 0; i < n_read_sel; i++) begin
         if ({dbread, eadr} == {1'b1, eadr_w'(i)}) begin
            read_sel[i] = 1'b1;
         end
      end
   end

   // Load strobes, address 0 to 11
   always_comb begin
      load_sel = '0;
      for (int i = 0; i < n_load_sel; i++) begin
         if ({dbwrite, eadr} == {1'b1, eadr_w'(i)}) begin
            load_sel[i] = 1'b1;
         end
      end
   end

   // Unmapped addresses leave both vectors empty
   assign hit = (|read_sel) || (|load_sel);

endmodule

// File: rtl/spy_machine_state.sv
// Loadable spy registers and a single-step stand-in for the processor
// Load strobes are one-hot; pc bits above 13 of the write data are dropped

`timescale 1ns/10ps

module spy_machine_state (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [spy_pkg::n_load_sel-1:0] load_sel,
   input  logic [spy_pkg::spy_data_w-1:0] spy_wdata,
   output logic [spy_pkg::dbir_w-1:0]     dbir,
   output logic [spy_pkg::mach_w-1:0]     md,
   output logic [spy_pkg::mach_w-1:0]     vma,
   output logic [spy_pkg::pc_w-1:0]       opc,
   output logic [spy_pkg::pc_w-1:0]       pc,
   output logic [spy_pkg::spy_data_w-1:0] mode,
   output logic [spy_pkg::spy_data_w-1:0] scratch1,
   output logic [spy_pkg::spy_data_w-1:0] scratch2,
   output logic [spy_pkg::mach_w-1:0]     st,
   output logic [spy_pkg::mach_w-1:0]     ob
);
   import spy_pkg::*;

   localparam int w = spy_data_w;

   // Diagnostic instruction, md and vma, written a 16-bit slice at a time
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbir <= '0;
         md   <= '0;
         vma  <= '0;
      end else begin
         if (load_sel[ld_dbirl]) begin
            dbir[w-1:0] <= spy_wdata;
         end
         if (load_sel[ld_dbirm]) begin
            dbir[2*w-1:w] <= spy_wdata;
         end
         if (load_sel[ld_dbirh]) begin
            dbir[3*w-1:2*w] <= spy_wdata;
         end
         if (load_sel[ld_mdl]) begin
            md[w-1:0] <= spy_wdata;
         end
         if (load_sel[ld_mdh]) begin
            md[2*w-1:w] <= spy_wdata;
         end
         if (load_sel[ld_vmal]) begin
            vma[w-1:0] <= spy_wdata;
         end
         if (load_sel[ld_vmah]) begin
            vma[2*w-1:w] <= spy_wdata;
         end
      end
   end

   // Mode and scratch words
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mode     <= '0;
         scratch1 <= '0;
         scratch2 <= '0;
      end else begin
         if (load_sel[ld_mode]) begin
            mode <= spy_wdata;
         end
         if (load_sel[ld_scratch1]) begin
            scratch1 <= spy_wdata;
         end
         if (load_sel[ld_scratch2]) begin
            scratch2 <= spy_wdata;
         end
      end
   end

   // Stand-in target: opc load sets pc, clock write steps once
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc  <= '0;
         opc <= '0;
         st  <= '0;
      end else if (load_sel[ld_opc]) begin
         opc <= pc;
         pc  <= spy_wdata[pc_w-1:0];
      end else if (load_sel[ld_clk]) begin
         opc <= pc;
         // pc wraps at 14 bits
         pc  <= pc + 1'b1;
         st  <= st + 1'b1;
      end
   end

   // Output bus of the stand-in target
   assign ob = md + vma;

endmodule

// File: rtl/spy_read_mux.sv
// Readback word for the examine port, OR of the selected sources
// Expects one-hot read selects; disk and bus-debug spies read as zero

`timescale 1ns/10ps

module spy_read_mux (
   input  logic [spy_pkg::n_read_sel-1:0] read_sel,
   input  logic [spy_pkg::dbir_w-1:0]     dbir,
   input  logic [spy_pkg::mach_w-1:0]     md,
   input  logic [spy_pkg::mach_w-1:0]     vma,
   input  logic [spy_pkg::pc_w-1:0]       opc,
   input  logic [spy_pkg::pc_w-1:0]       pc,
   input  logic [spy_pkg::spy_data_w-1:0] mode,
   input  logic [spy_pkg::spy_data_w-1:0] scratch1,
   input  logic [spy_pkg::spy_data_w-1:0] scratch2,
   input  logic [spy_pkg::mach_w-1:0]     st,
   input  logic [spy_pkg::mach_w-1:0]     ob,
   output logic [spy_pkg::spy_data_w-1:0] rd_word
);
   import spy_pkg::*;

   localparam int w = spy_data_w;

   logic [w-1:0] scratch_word;
   logic [w-1:0] flag2_word;

   function automatic logic [w-1:0] pick(input logic sel, input logic [w-1:0] val);
      return sel ? val : '0;
   endfunction

   // Mode bit 0 picks the second scratch word
   assign scratch_word = mode[0] ? scratch2 : scratch1;
   assign flag2_word   = {{(w-1){1'b0}}, (md == vma)};

   // Disk and bd selects add no term, so they read zero
   assign rd_word =
      pick(read_sel[rd_irl],     dbir[w-1:0])                       |
      pick(read_sel[rd_irm],     dbir[2*w-1:w])                     |
      pick(read_sel[rd_irh],     dbir[3*w-1:2*w])                   |
      pick(read_sel[rd_scratch], scratch_word)                      |
      pick(read_sel[rd_opc],     {{(w-pc_w){1'b0}}, opc})           |
      pick(read_sel[rd_pc],      {{(w-pc_w){1'b0}}, pc})            |
      pick(read_sel[rd_obl],     ob[w-1:0])                         |
      pick(read_sel[rd_obh],     ob[2*w-1:w])                       |
      pick(read_sel[rd_flag1],   mode)                              |
      pick(read_sel[rd_flag2],   flag2_word)                        |
      pick(read_sel[rd_ml] | read_sel[rd_mdl],  md[w-1:0])          |
      pick(read_sel[rd_mh] | read_sel[rd_mdh],  md[2*w-1:w])        |
      pick(read_sel[rd_al] | read_sel[rd_vmal], vma[w-1:0])         |
      pick(read_sel[rd_ah] | read_sel[rd_vmah], vma[2*w-1:w])       |
      pick(read_sel[rd_stl],     st[w-1:0])                         |
      pick(read_sel[rd_sth],     st[2*w-1:w])                       |
      pick(read_sel[rd_obl_n],   ~ob[w-1:0])                        |
      pick(read_sel[rd_obh_n],   ~ob[2*w-1:w]);

endmodule

// File: rtl/spy_top.sv
// Spy examine port with an AXI4-Lite host side and a stand-in target
// One cycle of latency per channel, plus any host back-pressure

`timescale 1ns/10ps

module spy_top (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [spy_pkg::axi_addr_w-1:0]    awaddr,
   input  logic                              awvalid,
   output logic                              awready,
   input  logic [spy_pkg::axi_data_w-1:0]    wdata,
   input  logic [spy_pkg::axi_data_w/8-1:0]  wstrb,
   input  logic                              wvalid,
   output logic                              wready,
   output logic [spy_pkg::resp_w-1:0]        bresp,
   output logic                              bvalid,
   input  logic                              bready,
   input  logic [spy_pkg::axi_addr_w-1:0]    araddr,
   input  logic                              arvalid,
   output logic                              arready,
   output logic [spy_pkg::axi_data_w-1:0]    rdata,
   output logic [spy_pkg::resp_w-1:0]        rresp,
   output logic                              rvalid,
   input  logic                              rready
);
   import spy_pkg::*;

   // Spy bus between the front end and the decoder
   logic [eadr_w-1:0]     eadr;
   logic                  dbread;
   logic                  dbwrite;
   logic [spy_data_w-1:0] spy_wdata;
   logic [spy_data_w-1:0] rd_word;
   logic                  hit;
   logic [n_read_sel-1:0] read_sel;
   logic [n_load_sel-1:0] load_sel;

   // Target state
   logic [dbir_w-1:0]     dbir;
   logic [mach_w-1:0]     md;
   logic [mach_w-1:0]     vma;
   logic [pc_w-1:0]       opc;
   logic [pc_w-1:0]       pc;
   logic [spy_data_w-1:0] mode;
   logic [spy_data_w-1:0] scratch1;
   logic [spy_data_w-1:0] scratch2;
   logic [mach_w-1:0]     st;
   logic [mach_w-1:0]     ob;

   spy_axil_slave u_slave (
      .clk, .rst_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
      .eadr, .dbread, .dbwrite, .spy_wdata, .rd_word, .hit
   );

   spy_decode u_decode (
      .eadr, .dbread, .dbwrite, .read_sel, .load_sel, .hit
   );

   spy_machine_state u_state (
      .clk, .rst_n, .load_sel, .spy_wdata,
      .dbir, .md, .vma, .opc, .pc, .mode, .scratch1, .scratch2, .st, .ob
   );

   spy_read_mux u_read_mux (
      .read_sel,
      .dbir, .md, .vma, .opc, .pc, .mode, .scratch1, .scratch2, .st, .ob,
      .rd_word
   );

endmodule

// File: verif/spy_tb.sv
// One bus transaction in flight at a time, responses checked in order
// against a register model kept here; address bits 1:0 are driven at random

`timescale 1ns/10ps

module spy_tb;
   import spy_pkg::*;

   // Well above the cycle count of all tests together
   localparam int timeout_cycles = 20000;
   localparam int exp_w          = 1 + resp_w + spy_data_w;

   logic                    clk;
   logic                    rst_n;
   logic [axi_addr_w-1:0]   awaddr;
   logic                    awvalid;
   logic                    awready;
   logic [axi_data_w-1:0]   wdata;
   logic [axi_data_w/8-1:0] wstrb;
   logic                    wvalid;
   logic                    wready;
   logic [resp_w-1:0]       bresp;
   logic                    bvalid;
   logic                    bready;
   logic [axi_addr_w-1:0]   araddr;
   logic                    arvalid;
   logic                    arready;
   logic [axi_data_w-1:0]   rdata;
   logic [resp_w-1:0]       rresp;
   logic                    rvalid;
   logic                    rready;

   // Register model
   logic [dbir_w-1:0]       m_dbir;
   logic [mach_w-1:0]       m_md;
   logic [mach_w-1:0]       m_vma;
   logic [pc_w-1:0]         m_opc;
   logic [pc_w-1:0]         m_pc;
   logic [spy_data_w-1:0]   m_mode;
   logic [spy_data_w-1:0]   m_s1;
   logic [spy_data_w-1:0]   m_s2;
   logic [mach_w-1:0]       m_st;

   // Expected responses as {is_read, resp, data}
   logic [exp_w-1:0]        exp_q[$];
   integer                  seed;
   int                      cycle_count;

   spy_top UUT (
      .clk, .rst_n,
      .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready,
      .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_fail(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_fail($sformatf("CHECK FAILED at %0t: %s = %b, expected %b",
                               $time, name, got, exp));
      end
   endtask

   task automatic check_resp(input string name, input logic [resp_w-1:0] got,
                             input logic [resp_w-1:0] exp);
      if (got !== exp) begin
         report_fail($sformatf("CHECK FAILED at %0t: %s = %b, expected %b",
                               $time, name, got, exp));
      end
   endtask

   task automatic check_data(input string name, input logic [axi_data_w-1:0] got,
                             input logic [axi_data_w-1:0] exp);
      if (got !== exp) begin
         report_fail($sformatf("CHECK FAILED at %0t: %s = %h, expected %h",
                               $time, name, got, exp));
      end
   endtask

   // Expected read word and response for one word address
   function automatic logic [exp_w-1:0] ref_read(input logic [eadr_w-1:0] a);
      logic [mach_w-1:0]     sum;
      logic [spy_data_w-1:0] w;
      sum = m_md + m_vma;
      case (a)
         rd_irl:           w = m_dbir[15:0];
         rd_irm:           w = m_dbir[31:16];
         rd_irh:           w = m_dbir[47:32];
         rd_scratch:       w = m_mode[0] ? m_s2 : m_s1;
         rd_opc:           w = {2'b00, m_opc};
         rd_pc:            w = {2'b00, m_pc};
         rd_obl:           w = sum[15:0];
         rd_obh:           w = sum[31:16];
         rd_flag1:         w = m_mode;
         rd_flag2:         w = {15'd0, m_md == m_vma};
         rd_ml, rd_mdl:    w = m_md[15:0];
         rd_mh, rd_mdh:    w = m_md[31:16];
         rd_al, rd_vmal:   w = m_vma[15:0];
         rd_ah, rd_vmah:   w = m_vma[31:16];
         rd_stl:           w = m_st[15:0];
         rd_sth:           w = m_st[31:16];
         rd_obl_n:         w = ~sum[15:0];
         rd_obh_n:         w = ~sum[31:16];
         // Disk, bd and unmapped addresses
         default:          w = '0;
      endcase
      return {1'b1, (a < n_read_sel) ? resp_okay : resp_slverr, w};
   endfunction

   task automatic model_write(input logic [eadr_w-1:0] a, input logic [spy_data_w-1:0] d);
      case (a)
         ld_dbirl:    m_dbir[15:0] = d;
         ld_dbirm:    m_dbir[31:16] = d;
         ld_dbirh:    m_dbir[47:32] = d;
         ld_clk: begin
            m_opc = m_pc;
            m_pc  = m_pc + 14'd1;
            m_st  = m_st + 32'd1;
         end
         ld_opc: begin
            m_opc = m_pc;
            m_pc  = d[pc_w-1:0];
         end
         ld_mode:     m_mode = d;
         ld_scratch1: m_s1 = d;
         ld_scratch2: m_s2 = d;
         ld_mdl:      m_md[15:0] = d;
         ld_mdh:      m_md[31:16] = d;
         ld_vmal:     m_vma[15:0] = d;
         ld_vmah:     m_vma[31:16] = d;
         default:     ;
      endcase
   endtask

   // Called on a rising edge; returns on the edge that takes the response
   task automatic bus_write(input logic [eadr_w-1:0] a, input logic [spy_data_w-1:0] d,
                            input logic [axi_data_w/8-1:0] strb, input int stall);
      logic full;
      full = &strb[1:0];
      exp_q.push_back({1'b0, (full && a >= n_load_sel) ? resp_slverr : resp_okay, 16'h0000});
      if (full) begin
         model_write(a, d);
      end
      awaddr  <= {a, 2'($random(seed))};
      wdata   <= {16'($random(seed)), d};
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      @(negedge clk);
      while (!awready) @(negedge clk);
      // Both channels are taken in the same cycle
      check_flag("wready", wready, 1'b1);
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      repeat (stall) @(posedge clk);
      bready <= 1'b1;
      @(negedge clk);
      while (!bvalid) @(negedge clk);
      @(posedge clk);
      bready <= 1'b0;
   endtask

   task automatic bus_read(input logic [eadr_w-1:0] a, input int stall);
      exp_q.push_back(ref_read(a));
      araddr  <= {a, 2'($random(seed))};
      arvalid <= 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      arvalid <= 1'b0;
      repeat (stall) @(posedge clk);
      rready <= 1'b1;
      @(negedge clk);
      while (!rvalid) @(negedge clk);
      @(posedge clk);
      rready <= 1'b0;
   endtask

   task automatic read_all();
      for (int a = 0; a < n_read_sel; a++) begin
         bus_read(5'(a), 0);
      end
   endtask

   // Each response is checked in the cycle before the host takes it
   always @(negedge clk) begin : compare
      logic [exp_w-1:0] e;
      if (rst_n && ((bvalid && bready) || (rvalid && rready))) begin
         if (exp_q.size() == 0) begin
            report_fail("A response arrived with no transaction outstanding");
         end else begin
            e = exp_q.pop_front();
            if (bvalid && bready) begin
               if (e[exp_w-1]) begin
                  report_fail("A write response arrived where a read response was due");
               end else begin
                  check_resp("bresp", bresp, e[spy_data_w +: resp_w]);
               end
            end else if (!e[exp_w-1]) begin
               report_fail("A read response arrived where a write response was due");
            end else begin
               check_resp("rresp", rresp, e[spy_data_w +: resp_w]);
               check_data("rdata", rdata, {16'h0000, e[spy_data_w-1:0]});
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > timeout_cycles) begin
         report_fail($sformatf("Timeout, tests did not finish in %0d cycles", timeout_cycles));
      end
   end

   initial begin : stimulus
      logic [31:0] r;
      logic [15:0] v;
      seed        = 32'h1a68_ade7;
      cycle_count = 0;
      rst_n   = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      m_dbir  = '0;
      m_md    = '0;
      m_vma   = '0;
      m_opc   = '0;
      m_pc    = '0;
      m_mode  = '0;
      m_s1    = '0;
      m_s2    = '0;
      m_st    = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // Reset state
      @(negedge clk);
      check_flag("bvalid", bvalid, 1'b0);
      check_flag("rvalid", rvalid, 1'b0);
      @(posedge clk);
      read_all();

      // Every loadable slice, then the scratch select
      for (int a = 0; a < n_load_sel; a++) begin
         if (a != ld_clk && a != ld_opc) begin
            bus_write(5'(a), 16'($random(seed)), 4'hf, 0);
            read_all();
         end
      end
      bus_write(ld_mode, 16'h0001, 4'hf, 0);
      bus_read(rd_scratch, 0);
      bus_write(ld_mode, 16'h0000, 4'hf, 0);
      bus_read(rd_scratch, 0);

      // Single steps, first across the 14-bit wrap
      for (int k = 0; k < 3; k++) begin
         v = (k == 0) ? 16'hfffd : 16'($random(seed));
         bus_write(ld_opc, v, 4'hf, 0);
         repeat (k * 3 + 5) bus_write(ld_clk, 16'($random(seed)), 4'hf, 0);
         bus_read(rd_pc, 0);
         bus_read(rd_opc, 0);
         bus_read(rd_stl, 0);
         bus_read(rd_sth, 0);
      end

      // Output bus sum, odd rounds with md equal to vma
      for (int i = 0; i < 8; i++) begin
         r = $random(seed);
         bus_write(ld_mdl, r[15:0], 4'hf, 0);
         bus_write(ld_mdh, r[31:16], 4'hf, 0);
         if (i % 2 == 0) begin
            r = $random(seed);
         end
         bus_write(ld_vmal, r[15:0], 4'hf, 0);
         bus_write(ld_vmah, r[31:16], 4'hf, 0);
         bus_read(rd_obl, 0);
         bus_read(rd_obh, 0);
         bus_read(rd_obl_n, 0);
         bus_read(rd_obh_n, 0);
         bus_read(rd_flag2, 0);
      end

      // Unmapped addresses and partial strobes
      for (int a = n_load_sel; a < 32; a++) begin
         bus_write(5'(a), 16'($random(seed)), 4'hf, 0);
      end
      for (int a = n_read_sel; a < 32; a++) begin
         bus_read(5'(a), 0);
      end
      bus_write(ld_scratch1, 16'($random(seed)), 4'b0001, 0);
      bus_write(ld_mdh, 16'($random(seed)), 4'b0010, 0);
      bus_write(ld_clk, 16'($random(seed)), 4'b1100, 0);
      bus_write(ld_opc, 16'($random(seed)), 4'b0000, 0);
      read_all();

      // Mixed random traffic with response stalls
      for (int i = 0; i < 300; i++) begin
         r = $random(seed);
         if (r[0]) begin
            bus_write(r[5:1], r[31:16], (r[7:6] == 2'b00) ? r[11:8] : 4'hf, r[13:12]);
         end else begin
            bus_read(r[5:1], r[13:12]);
         end
      end

      repeat (2) @(posedge clk);
      if (exp_q.size() == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         report_fail($sformatf("%0d expected responses never arrived", exp_q.size()));
      end
   end

endmodule

// File: verilog.f
rtl/spy_pkg.sv
rtl/spy_axil_slave.sv
rtl/spy_decode.sv
rtl/spy_machine_state.sv
rtl/spy_read_mux.sv
rtl/spy_top.sv
verif/spy_tb.sv
